//--- ahb_data_phase.sv
`timescale 1ns/100ps

module ahb_data_phase
(
  input  logic                           HCLK,           // AHB clock
  input  logic                           HRESETn,        // Sync reset, active low
  input  logic                           i_hreadyout,    // Slave HREADYOUT
  input  ahb_matrix_pkg::ahb_addr_ctrl_t i_m_ac,         // Granted address phase
  input  ahb_matrix_pkg::port_id_t       i_addr_port,    // Address-phase port
  output ahb_matrix_pkg::port_id_t       o_data_port,    // Data-phase port
  output logic                           o_wdata_phase,  // Real transfer in data phase
  output logic                           o_hreadymux     // HREADYMUXM
);

  ahb_matrix_pkg::port_id_t data_port;    // Port owning the data phase
  logic                     wdata_phase;  // Gates HWDATA toggling
  logic                     slave_sel;    // Slave selected last accepted cycle
  logic                     hreadymux;    // Internal HREADYMUXM
  logic                     real_xfer;    // NONSEQ or SEQ with HSEL

  assign real_xfer = i_m_ac.sel
                     && (i_m_ac.trans inside {ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SEQ});

  // ----------------------------------------
  // Data phase registers
  // ----------------------------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port   <= '1;
      wdata_phase <= 1'b0;
      slave_sel   <= 1'b0;
    end
    else if (hreadymux)  // Advance only when the phase completes
    begin
      data_port   <= i_addr_port;
      wdata_phase <= real_xfer;
      slave_sel   <= i_m_ac.sel;
    end
  end

  // ----------------------------------------
  // HREADYMUXM generation
  // ----------------------------------------

  // Slave drives ready only while it owns the data phase
  assign hreadymux = slave_sel ? i_hreadyout : 1'b1;

  assign o_data_port   = data_port;
  assign o_wdata_phase = wdata_phase;
  assign o_hreadymux   = hreadymux;

  // Unselected accepted cycle leaves the next data phase ready
  a_ready_unsel : assert property (@(posedge HCLK) disable iff (!HRESETn)
    hreadymux && !i_m_ac.sel |=> !slave_sel && o_hreadymux)
    else $error("ahb_data_phase: HREADYMUXM low without slave select");

endmodule

//--- ahb_lock_track.sv
`timescale 1ns/100ps

module ahb_lock_track
(
  input  logic                           HCLK,       // AHB clock
  input  logic                           HRESETn,    // Sync reset, active low
  input  logic                           i_hready,   // HREADYMUXM feedback
  input  ahb_matrix_pkg::ahb_addr_ctrl_t i_m_ac,     // Granted address phase
  output logic                           o_lock_arb  // Lock seen by arbiter
);

  logic lock_flag;       // Locked sequence started here
  logic next_lock_flag;  // Value for next accepted edge
  logic lock_start;      // Locked real transfer to this slave

  // ----------------------------------------
  // Locked sequence flag
  // ----------------------------------------

  assign lock_start = i_m_ac.sel
                      && (i_m_ac.trans inside {ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SEQ})
                      && i_m_ac.mastlock;

  // Survives HSEL low while master addresses elsewhere
  always_comb
  begin
    next_lock_flag = lock_flag;
    if (lock_start)
    begin
      next_lock_flag = 1'b1;  // Sequence began on this slave
    end
    else if (!i_m_ac.mastlock)
    begin
      next_lock_flag = 1'b0;  // Master released the bus
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      lock_flag <= 1'b0;
    end
    else if (i_hready)
    begin
      lock_flag <= next_lock_flag;
    end
  end

  // Mastlock ignored until this slave is actually part of the sequence
  assign o_lock_arb = i_m_ac.mastlock & (lock_flag | i_m_ac.sel);

endmodule

//--- ahb_matrix_params.svh
`ifndef AHB_MATRIX_PARAMS_SVH
`define AHB_MATRIX_PARAMS_SVH

// ----------------------------------------
// Output stage sizing
// ----------------------------------------

`define AHB_NUM_PORTS 4   // Bus-switch input ports per output stage
`define AHB_ADDR_W    32  // HADDR width
`define AHB_DATA_W    32  // HWDATA width
`define AHB_PROT_W    4   // HPROT width
`define AHB_MASTER_W  4   // HMASTER width

`endif

//--- ahb_matrix_pkg.sv
`include "ahb_matrix_params.svh"

package ahb_matrix_pkg;

  // ----------------------------------------
  // Port index and transfer encodings
  // ----------------------------------------

  typedef logic [$clog2(`AHB_NUM_PORTS)-1:0] port_id_t;  // Input port number

  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master inserting a wait in a burst
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Remaining beats
  } htrans_t;

  typedef enum logic [2:0]
  {
    SINGLE = 3'b000,  // Only code that releases a held grant
    INCR   = 3'b001,  // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // ----------------------------------------
  // Address phase of one port
  // ----------------------------------------

  typedef struct packed
  {
    logic                      sel;       // HSEL for this slave
    logic [`AHB_ADDR_W-1:0]    addr;      // HADDR
    htrans_t                   trans;     // HTRANS
    logic                      write;     // HWRITE
    logic [2:0]                size;      // HSIZE
    hburst_t                   burst;     // HBURST
    logic [`AHB_PROT_W-1:0]    prot;      // HPROT
    logic [`AHB_MASTER_W-1:0]  master;    // HMASTER
    logic                      mastlock;  // HMASTLOCK
  } ahb_addr_ctrl_t;

  typedef logic [`AHB_DATA_W-1:0] wdata_t;  // HWDATA of one port

endpackage

//--- ahb_out_arbiter.sv
`timescale 1ns/100ps

`include "ahb_matrix_params.svh"

module ahb_out_arbiter
(
  input  logic                           HCLK,         // AHB clock
  input  logic                           HRESETn,      // Sync reset, active low
  input  logic [`AHB_NUM_PORTS-1:0]      i_req,        // Qualified port requests
  input  logic                           i_hready,     // HREADYMUXM feedback
  input  ahb_matrix_pkg::ahb_addr_ctrl_t i_m_ac,       // Granted address phase
  input  logic                           i_lock,       // Masked HMASTLOCK
  output ahb_matrix_pkg::port_id_t       o_addr_port,  // Address-phase port
  output logic                           o_no_port     // Nothing granted
);

  ahb_matrix_pkg::port_id_t addr_port;       // Registered grant
  ahb_matrix_pkg::port_id_t next_addr_port;  // Grant for next accepted edge
  ahb_matrix_pkg::port_id_t low_port;        // Lowest requesting port
  logic                     no_port;         // Registered idle flag
  logic                     next_no_port;    // Idle flag for next edge
  logic                     any_req;         // At least one request
  logic                     burst_hold;      // Burst still in progress

  // ----------------------------------------
  // Fixed priority encoder
  // ----------------------------------------

  always_comb
  begin
    low_port = '0;
    for (int n = `AHB_NUM_PORTS - 1; n >= 0; n--)
    begin
      if (i_req[n])
      begin
        low_port = ahb_matrix_pkg::port_id_t'(n);  // Lower index overrides
      end
    end
  end

  assign any_req = |i_req;

  // Granted master mid-burst, no beat counting
  assign burst_hold = !no_port
                      && (i_m_ac.trans != ahb_matrix_pkg::IDLE)
                      && (i_m_ac.burst != ahb_matrix_pkg::SINGLE);

  // ----------------------------------------
  // Next grant
  // ----------------------------------------

  always_comb
  begin
    next_addr_port = addr_port;  // Hold by default
    next_no_port   = no_port;
    if (i_lock)
    begin
      next_addr_port = addr_port;  // Locked sequence owns the slave
      next_no_port   = no_port;
    end
    else if (burst_hold)
    begin
      next_addr_port = addr_port;  // Finish the burst first
      next_no_port   = 1'b0;
    end
    else if (any_req)
    begin
      next_addr_port = low_port;  // New winner
      next_no_port   = 1'b0;
    end
    else
    begin
      next_no_port   = 1'b1;  // Park with no owner
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      addr_port <= '1;
      no_port   <= 1'b1;
    end
    else if (i_hready)  // Only on accepted edges
    begin
      addr_port <= next_addr_port;
      no_port   <= next_no_port;
    end
  end

  assign o_addr_port = addr_port;
  assign o_no_port   = no_port;

  // Stalled slave must not see the owner switch under it
  a_grant_stable : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hready |=> $stable(addr_port) && $stable(no_port))
    else $error("ahb_out_arbiter: grant changed while HREADYMUXM low");

endmodule

//--- ahb_output_stage.sv
`timescale 1ns/100ps

`include "ahb_matrix_params.svh"

module ahb_output_stage
(
  input  logic                           HCLK,                           // AHB clock
  input  logic                           HRESETn,                        // Sync reset
  input  ahb_matrix_pkg::ahb_addr_ctrl_t i_port_ac    [`AHB_NUM_PORTS],  // Port addr/ctrl
  input  ahb_matrix_pkg::wdata_t         i_port_wdata [`AHB_NUM_PORTS],  // Port HWDATA
  input  logic [`AHB_NUM_PORTS-1:0]      i_held_tran,                    // Held transfer
  input  logic                           i_hreadyout,                    // Slave HREADYOUT
  output logic [`AHB_NUM_PORTS-1:0]      o_active,                       // Port owns slave
  output ahb_matrix_pkg::ahb_addr_ctrl_t o_m_ac,                         // Slave addr/ctrl
  output ahb_matrix_pkg::wdata_t         o_hwdata,                       // Slave HWDATA
  output logic                           o_hreadymux                     // HREADYMUXM
);

  logic [`AHB_NUM_PORTS-1:0]      req;          // Qualified requests
  ahb_matrix_pkg::port_id_t       addr_port;    // Address-phase grant
  ahb_matrix_pkg::port_id_t       data_port;    // Data-phase owner
  logic                           no_port;      // No grant
  logic                           wdata_phase;  // Write data enable
  logic                           lock_arb;     // Lock for arbitration
  logic                           hreadymux;    // Internal HREADYMUXM
  ahb_matrix_pkg::ahb_addr_ctrl_t m_ac;         // Granted address phase

  // ----------------------------------------
  // Request qualification and active decode
  // ----------------------------------------

  always_comb
  begin
    for (int n = 0; n < `AHB_NUM_PORTS; n++)
    begin
      req[n] = i_held_tran[n] & i_port_ac[n].sel;  // Held transfer aimed here
    end
  end

  always_comb
  begin
    o_active = '0;
    if (!no_port)
    begin
      o_active[addr_port] = 1'b1;  // One-hot back to the owner
    end
  end

  // ----------------------------------------
  // Arbitration and lock
  // ----------------------------------------

  ahb_out_arbiter u_output_arb
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_req       (req),
    .i_hready    (hreadymux),
    .i_m_ac      (m_ac),
    .i_lock      (lock_arb),
    .o_addr_port (addr_port),
    .o_no_port   (no_port)
  );

  ahb_lock_track u_lock_track
  (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .i_hready   (hreadymux),
    .i_m_ac     (m_ac),
    .o_lock_arb (lock_arb)
  );

  // ----------------------------------------
  // Muxes and data phase
  // ----------------------------------------

  ahb_port_mux #(.payload_t(ahb_matrix_pkg::ahb_addr_ctrl_t)) u_addr_mux
  (
    .i_sel     (addr_port),
    .i_en      (!no_port),  // Zero bus when nobody owns it
    .i_payload (i_port_ac),
    .o_payload (m_ac)
  );

  ahb_data_phase u_data_phase
  (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_hreadyout   (i_hreadyout),
    .i_m_ac        (m_ac),
    .i_addr_port   (addr_port),
    .o_data_port   (data_port),
    .o_wdata_phase (wdata_phase),
    .o_hreadymux   (hreadymux)
  );

  ahb_port_mux #(.payload_t(ahb_matrix_pkg::wdata_t)) u_wdata_mux
  (
    .i_sel     (data_port),
    .i_en      (wdata_phase),  // Only during a real data phase
    .i_payload (i_port_wdata),
    .o_payload (o_hwdata)
  );

  assign o_m_ac      = m_ac;
  assign o_hreadymux = hreadymux;

endmodule

//--- ahb_port_mux.sv
`timescale 1ns/100ps

`include "ahb_matrix_params.svh"

module ahb_port_mux
#(
  parameter type payload_t = logic  // Per-port payload being routed
)
(
  input  ahb_matrix_pkg::port_id_t i_sel,                        // Port to route
  input  logic                     i_en,                         // Routing enabled
  input  payload_t                 i_payload [`AHB_NUM_PORTS],   // One payload per port
  output payload_t                 o_payload                     // Routed payload
);

  // ----------------------------------------
  // Selection
  // ----------------------------------------

  always_comb
  begin
    o_payload = payload_t'('0);  // Quiet bus when disabled
    if (i_en)
    begin
      o_payload = i_payload[i_sel];  // Pass the chosen port through
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the output stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_ahb_output_stage \
  -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

//--- src.f
+incdir+.
ahb_matrix_pkg.sv
ahb_port_mux.sv
ahb_out_arbiter.sv
ahb_lock_track.sv
ahb_data_phase.sv
ahb_output_stage.sv
tb_ahb_output_stage.sv

//--- tb_ahb_output_stage.sv
`timescale 1ns/100ps

`include "ahb_matrix_params.svh"

module tb_ahb_output_stage;

  localparam int TEST_CYCLES = 12 + 20 + 30 + 30 + 60 + 40;  // Budgets of the six tests
  localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;          // Plus half again

  typedef struct packed
  {
    ahb_matrix_pkg::port_id_t grant;        // Address-phase port
    logic                     no_port;      // Nobody owns the slave
    logic                     lock_flag;    // Locked sequence open
    ahb_matrix_pkg::port_id_t data_port;    // Data-phase port
    logic                     wdata_phase;  // Real transfer in data phase
    logic                     slave_sel;    // Slave selected on last accepted edge
  } model_t;

  localparam model_t MODEL_RST = '{grant: '1, no_port: 1'b1, lock_flag: 1'b0,
                                   data_port: '1, wdata_phase: 1'b0, slave_sel: 1'b0};

  logic                           HCLK;
  logic                           HRESETn;
  ahb_matrix_pkg::ahb_addr_ctrl_t port_ac    [`AHB_NUM_PORTS];
  ahb_matrix_pkg::wdata_t         port_wdata [`AHB_NUM_PORTS];
  logic [`AHB_NUM_PORTS-1:0]      held_tran;
  logic                           hreadyout;
  logic [`AHB_NUM_PORTS-1:0]      active;
  ahb_matrix_pkg::ahb_addr_ctrl_t m_ac;
  ahb_matrix_pkg::wdata_t         hwdata;
  logic                           hreadymux;
  model_t                         model = MODEL_RST;       // Reference state
  model_t                         model_next = MODEL_RST;  // State for next edge
  logic                           started = 1'b0;          // First edge seen
  int                             cycle_cnt = 0;
  int                             errors = 0;
  int                             checks = 0;
  int                             test_errors0;
  int                             test_checks0;
  string                          test_name;
  logic [`AHB_NUM_PORTS-1:0]      exp_active;
  ahb_matrix_pkg::ahb_addr_ctrl_t exp_ac;
  ahb_matrix_pkg::wdata_t         exp_wdata;
  logic                           exp_rdy;

  ahb_output_stage UUT
  (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ac    (port_ac),
    .i_port_wdata (port_wdata),
    .i_held_tran  (held_tran),
    .i_hreadyout  (hreadyout),
    .o_active     (active),
    .o_m_ac       (m_ac),
    .o_hwdata     (hwdata),
    .o_hreadymux  (hreadymux)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;  // 100 ns period
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic model_t exp_grant(input model_t s);
    model_t                         n;
    ahb_matrix_pkg::ahb_addr_ctrl_t cur;
    logic [`AHB_NUM_PORTS-1:0]      req;
    logic                           xfer;
    logic                           found;
    int                             i;
    n   = s;
    cur = s.no_port ? '0 : port_ac[s.grant];  // Bus the slave sees now
    for (i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      req[i] = held_tran[i] & port_ac[i].sel;
    end
    if (s.slave_sel && !hreadyout)
    begin
      return s;  // Stalled edge, nothing moves
    end
    xfer = cur.sel && (cur.trans == ahb_matrix_pkg::NONSEQ || cur.trans == ahb_matrix_pkg::SEQ);
    if (cur.mastlock && (s.lock_flag || cur.sel))
    begin
      n.no_port = s.no_port;  // Locked owner keeps it
    end
    else if (!s.no_port && cur.trans != ahb_matrix_pkg::IDLE
             && cur.burst != ahb_matrix_pkg::SINGLE)
    begin
      n.no_port = 1'b0;  // Burst still running
    end
    else
    begin
      found = 1'b0;
      for (i = 0; i < `AHB_NUM_PORTS; i++)
      begin
        if (req[i] && !found)
        begin
          n.grant = ahb_matrix_pkg::port_id_t'(i);  // Lowest index wins
          found   = 1'b1;
        end
      end
      n.no_port = !found;
    end
    if (xfer && cur.mastlock)
    begin
      n.lock_flag = 1'b1;
    end
    else if (!cur.mastlock)
    begin
      n.lock_flag = 1'b0;
    end
    n.data_port   = s.grant;
    n.wdata_phase = xfer;
    n.slave_sel   = cur.sel;
    return n;
  endfunction

  function automatic ahb_matrix_pkg::ahb_addr_ctrl_t make_ac(input logic sel,
      input ahb_matrix_pkg::htrans_t trans, input ahb_matrix_pkg::hburst_t burst,
      input logic write, input logic lock, input logic [3:0] master);
    ahb_matrix_pkg::ahb_addr_ctrl_t ac;
    logic [31:0]                    rnd;
    rnd         = $urandom;
    ac.sel      = sel;
    ac.addr     = $urandom;
    ac.trans    = trans;
    ac.write    = write;
    ac.size     = 3'd2;  // Word
    ac.burst    = burst;
    ac.prot     = rnd[3:0];
    ac.master   = master;
    ac.mastlock = lock;
    return ac;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_ac(input string name, input ahb_matrix_pkg::ahb_addr_ctrl_t got,
                          input ahb_matrix_pkg::ahb_addr_ctrl_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_wdata(input string name, input ahb_matrix_pkg::wdata_t got,
                             input ahb_matrix_pkg::wdata_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_bits(input string name, input logic [`AHB_NUM_PORTS-1:0] got,
                            input logic [`AHB_NUM_PORTS-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
    end
  endtask

  always @(negedge HCLK)  // Outputs settled, inputs fixed until next edge
  begin
    if (started)
    begin
      exp_active = '0;
      if (!model.no_port)
      begin
        exp_active[model.grant] = 1'b1;
      end
      exp_ac    = model.no_port ? '0 : port_ac[model.grant];
      exp_wdata = model.wdata_phase ? port_wdata[model.data_port] : '0;
      exp_rdy   = model.slave_sel ? hreadyout : 1'b1;
      check_bits("o_active", active, exp_active);
      check_ac("o_m_ac", m_ac, exp_ac);
      check_wdata("o_hwdata", hwdata, exp_wdata);
      check_bits("o_hreadymux", {3'b000, hreadymux}, {3'b000, exp_rdy});
    end
    model_next = (HRESETn === 1'b1) ? exp_grant(model) : MODEL_RST;
  end

  always @(posedge HCLK)
  begin
    model     <= model_next;
    started   <= 1'b1;
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  task automatic start_test(input string name);
    test_name    = name;
    test_errors0 = errors;
    test_checks0 = checks;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks0,
             errors - test_errors0);
  endtask

  task idle_all();
    int i;
    @(posedge HCLK);
    for (i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      port_ac[i] <= '0;
    end
    held_tran <= '0;
  endtask

  task automatic wait_active(input int k, input int limit);
    logic [`AHB_NUM_PORTS-1:0] want;
    int                        n;
    want = '0;
    if (k >= 0)
    begin
      want[k] = 1'b1;  // Negative k waits for no owner
    end
    n = 0;
    @(negedge HCLK);
    while (active !== want && n < limit)
    begin
      @(negedge HCLK);
      n++;
    end
    if (active !== want)
    begin
      errors++;
      $display("error: o_active never reached %h within %0d cycles", want, limit);
    end
  endtask

  task automatic hold_check(input int k, input int cycles);
    logic [`AHB_NUM_PORTS-1:0] want;
    want    = '0;
    want[k] = 1'b1;
    repeat (cycles)
    begin
      @(negedge HCLK);
      check_bits("o_active", active, want);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  initial
  begin
    int                        i;
    int                        stalls;
    logic                      accept;
    logic [`AHB_NUM_PORTS-1:0] prev_active;
    ahb_matrix_pkg::wdata_t    prev_wdata;
    void'($urandom(32'ha845));
    HRESETn   <= 1'b0;
    held_tran <= '0;
    hreadyout <= 1'b1;
    for (i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      port_ac[i]    <= '0;
      port_wdata[i] <= $urandom;
    end

    start_test("reset");
    repeat (10) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check_bits("o_active", active, '0);
    check_ac("o_m_ac", m_ac, '0);
    check_wdata("o_hwdata", hwdata, '0);
    check_bits("o_hreadymux", {3'b000, hreadymux}, 4'b0001);
    end_test();

    start_test("single_request");
    @(posedge HCLK);
    port_ac[2]   <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b0, 1'b0, 4'd2);
    held_tran[2] <= 1'b1;
    wait_active(2, 10);
    check_ac("o_m_ac", m_ac, port_ac[2]);
    idle_all();
    wait_active(-1, 10);
    end_test();

    start_test("priority");
    @(posedge HCLK);
    port_ac[0] <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b0, 1'b0, 4'd0);
    port_ac[1] <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b0, 1'b0, 4'd1);
    port_ac[3] <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b0, 1'b0, 4'd3);
    held_tran  <= 4'b1011;
    wait_active(0, 10);
    @(posedge HCLK);
    port_ac[0]   <= '0;
    held_tran[0] <= 1'b0;
    wait_active(1, 10);
    @(posedge HCLK);
    port_ac[1]   <= '0;
    held_tran[1] <= 1'b0;
    wait_active(3, 10);
    idle_all();
    wait_active(-1, 10);
    end_test();

    start_test("burst_hold");
    @(posedge HCLK);
    port_ac[2]   <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::INCR, 1'b0, 1'b0, 4'd2);
    held_tran[2] <= 1'b1;
    wait_active(2, 10);
    @(posedge HCLK);
    port_ac[2]   <= make_ac(1'b1, ahb_matrix_pkg::SEQ, ahb_matrix_pkg::INCR, 1'b0, 1'b0, 4'd2);
    port_ac[0]   <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b0, 1'b0, 4'd0);
    held_tran[0] <= 1'b1;
    hold_check(2, 6);
    @(posedge HCLK);
    port_ac[2]   <= make_ac(1'b1, ahb_matrix_pkg::IDLE, ahb_matrix_pkg::INCR, 1'b0, 1'b0, 4'd2);
    held_tran[2] <= 1'b0;
    wait_active(0, 10);
    idle_all();
    wait_active(-1, 10);
    end_test();

    start_test("write_backpressure");
    @(posedge HCLK);
    port_ac[3]    <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b1, 1'b0, 4'd3);
    port_wdata[3] <= $urandom;
    held_tran[3]  <= 1'b1;
    port_ac[1]    <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE,
                             1'b1, 1'b0, 4'd1);  // Addressed, not yet requesting
    wait_active(3, 10);
    stalls = 0;
    for (i = 0; i < 30; i++)
    begin
      accept      = hreadymux;  // Ready seen by the coming edge
      prev_active = active;
      prev_wdata  = hwdata;
      @(posedge HCLK);
      if (accept)
      begin
        port_ac[3] <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE,
                              1'b1, 1'b0, 4'd3);
        port_wdata[3] <= $urandom;
        port_ac[1]    <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE,
                                 1'b1, 1'b0, 4'd1);
        port_wdata[1] <= $urandom;
        held_tran[1]  <= ($urandom % 2 != 0);  // Port 1 comes and goes, owner moves
      end
      hreadyout <= (i == 5) ? 1'b0 : ($urandom % 4 != 0);  // One stall for sure
      @(negedge HCLK);
      if (!accept)
      begin
        stalls++;
        check_bits("o_active", active, prev_active);
        check_wdata("o_hwdata", hwdata, prev_wdata);
      end
    end
    @(posedge HCLK);
    hreadyout <= 1'b1;
    idle_all();
    wait_active(-1, 10);
    if (stalls == 0)
    begin
      errors++;
      $display("error: no stalled edge seen during the back-pressure test");
    end
    end_test();

    start_test("locked_sequence");
    @(posedge HCLK);
    port_ac[1]   <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b0, 1'b1, 4'd1);
    held_tran[1] <= 1'b1;
    wait_active(1, 10);
    @(posedge HCLK);
    port_ac[1]   <= make_ac(1'b0, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b0, 1'b1, 4'd1);
    held_tran[1] <= 1'b0;
    port_ac[0]   <= make_ac(1'b1, ahb_matrix_pkg::NONSEQ, ahb_matrix_pkg::SINGLE, 1'b1, 1'b0, 4'd0);
    held_tran[0] <= 1'b1;
    hold_check(1, 6);
    @(posedge HCLK);
    port_ac[1] <= make_ac(1'b0, ahb_matrix_pkg::IDLE, ahb_matrix_pkg::SINGLE, 1'b0, 1'b0, 4'd1);
    wait_active(0, 10);
    idle_all();
    wait_active(-1, 10);
    end_test();

    $display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycle_cnt);
    if (errors == 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
